//--- hw/fpu_defines.svh
// Binary32 field widths, exponent bias, internal widths and special encodings
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// Word and field widths
`define FPU_WORD_W 32
`define FPU_EXP_W 8
`define FPU_MANT_W 23

// Exponent bias and the all-ones exponent of inf and NaN
`define FPU_BIAS 127
`define FPU_EXP_INF 8'hff

// Signed exponent before normalization, wide enough to see overflow and underflow
`define FPU_PRENORM_EXP_W 10
// Mantissa before normalization, sized for the full product
`define FPU_PRENORM_MANT_W 48

// Canonical quiet NaN
`define FPU_QNAN 32'h7fc00000

`endif

//--- hw/fpu_pkg.sv
// Opcode, operand class and special outcome enums, result flag struct
package fpu_pkg;

   // Supported operations
   typedef enum logic [1:0]
   {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2
   } fpu_op_e;

   // Operand class, subnormals fold into zero
   typedef enum logic [1:0]
   {
      CLASS_ZERO   = 2'd0,
      CLASS_NORMAL = 2'd1,
      CLASS_INF    = 2'd2,
      CLASS_NAN    = 2'd3
   } fpu_class_e;

   // Outcome that bypasses the rounded datapath
   typedef enum logic [1:0]
   {
      SPECIAL_NONE = 2'd0,
      SPECIAL_ZERO = 2'd1,
      SPECIAL_INF  = 2'd2,
      SPECIAL_QNAN = 2'd3
   } fpu_special_e;

   // Result flags
   typedef struct packed
   {
      logic of;
      logic uf;
      logic zero;
      logic ix;
      logic iv;
      logic inf;
   } fpu_flags_t;

endpackage

//--- hw/fpu_if.sv
// Stage interfaces fpu_operand_if and fpu_result_if with their modports
`include "fpu_defines.svh"

//////////////////////////////////////////////////////////////////////
// Unpacked operands, operand stage to datapath
//////////////////////////////////////////////////////////////////////
interface fpu_operand_if;
   logic                  valid;
   fpu_pkg::fpu_op_e      op;
   // Operand a, mantissa carries the hidden bit
   logic                  sign_a;
   logic [`FPU_EXP_W-1:0] exp_a;
   logic [`FPU_MANT_W:0]  mant_a;
   fpu_pkg::fpu_class_e   class_a;
   // Operand b, sign already flipped for subtract
   logic                  sign_b;
   logic [`FPU_EXP_W-1:0] exp_b;
   logic [`FPU_MANT_W:0]  mant_b;
   fpu_pkg::fpu_class_e   class_b;

   modport source (output valid, op, sign_a, exp_a, mant_a, class_a,
                   sign_b, exp_b, mant_b, class_b);
   modport sink (input valid, op, sign_a, exp_a, mant_a, class_a,
                 sign_b, exp_b, mant_b, class_b);
endinterface

//////////////////////////////////////////////////////////////////////
// Rounded result, rounding stage to output stage
//////////////////////////////////////////////////////////////////////
interface fpu_result_if;
   logic                                valid;
   logic                                sign;
   // Biased, may still be out of range
   logic signed [`FPU_PRENORM_EXP_W-1:0] exp;
   logic [`FPU_MANT_W:0]                mant;
   logic                                inexact;
   fpu_pkg::fpu_special_e               special;

   modport source (output valid, sign, exp, mant, inexact, special);
   modport sink (input valid, sign, exp, mant, inexact, special);
endinterface

//--- hw/fpu_operand_stage.sv
// Input register, operand unpacking, subtract sign flip and operand classification
`include "fpu_defines.svh"

module fpu_operand_stage
(
   input  logic                   Clk_CI,
   input  logic                   Rst_RBI,
   input  logic                   enable,
   input  logic [`FPU_WORD_W-1:0] operand_a,
   input  logic [`FPU_WORD_W-1:0] operand_b,
   input  fpu_pkg::fpu_op_e       op,
   fpu_operand_if.source          opnd
);

   logic                   valid_q;
   fpu_pkg::fpu_op_e       op_q;
   logic [`FPU_WORD_W-1:0] a_q;
   logic [`FPU_WORD_W-1:0] b_q;

   // Class from exponent and fraction
   function automatic fpu_pkg::fpu_class_e classify(input logic [`FPU_EXP_W-1:0] exp,
                                                    input logic [`FPU_MANT_W-1:0] frac);
      if (exp == '0)
         return fpu_pkg::CLASS_ZERO;
      else if (exp != `FPU_EXP_INF)
         return fpu_pkg::CLASS_NORMAL;
      else if (frac == '0)
         return fpu_pkg::CLASS_INF;
      else
         return fpu_pkg::CLASS_NAN;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Request register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
         valid_q <= 1'b0;
      else
         valid_q <= enable;
   end

   // Payload, taken every cycle
   always_ff @(posedge Clk_CI)
   begin
      op_q <= op;
      a_q  <= operand_a;
      b_q  <= operand_b;
   end

   // Field split
   assign opnd.valid  = valid_q;
   assign opnd.op     = op_q;
   assign opnd.sign_a = a_q[`FPU_WORD_W-1];
   assign opnd.exp_a  = a_q[`FPU_WORD_W-2:`FPU_MANT_W];
   // Subtract is add with b negated
   assign opnd.sign_b = b_q[`FPU_WORD_W-1] ^ (op_q == fpu_pkg::OP_SUB);
   assign opnd.exp_b  = b_q[`FPU_WORD_W-2:`FPU_MANT_W];

   // Hidden bit from a nonzero exponent, subnormals read as zero
   assign opnd.mant_a = (|opnd.exp_a) ? {1'b1, a_q[`FPU_MANT_W-1:0]} : '0;
   assign opnd.mant_b = (|opnd.exp_b) ? {1'b1, b_q[`FPU_MANT_W-1:0]} : '0;

   assign opnd.class_a = classify(opnd.exp_a, a_q[`FPU_MANT_W-1:0]);
   assign opnd.class_b = classify(opnd.exp_b, b_q[`FPU_MANT_W-1:0]);

endmodule

//--- hw/fpu_add_path.sv
// Add path with exponent alignment, sticky collection and signed-magnitude add
`include "fpu_defines.svh"

module fpu_add_path
(
   fpu_operand_if.sink                         opnd,
   output logic                                sign,
   output logic signed [`FPU_PRENORM_EXP_W-1:0] exp,
   output logic [`FPU_PRENORM_MANT_W-1:0]       mant
);

   logic                           a_big;
   logic                           sub;
   logic [`FPU_EXP_W-1:0]          exp_big;
   logic [`FPU_EXP_W-1:0]          exp_diff;
   logic [`FPU_MANT_W:0]           mant_big;
   logic [`FPU_MANT_W:0]           mant_small;
   logic [`FPU_PRENORM_MANT_W-1:0] big_al;
   logic [`FPU_PRENORM_MANT_W-1:0] small_al;
   logic [`FPU_PRENORM_MANT_W-1:0] small_sh;
   logic                           sticky;

   //////////////////////////////////////////////////////////////////////
   // Operand swap
   //////////////////////////////////////////////////////////////////////
   // Magnitude compare, exponent first, then mantissa
   assign a_big = {opnd.exp_a, opnd.mant_a} >= {opnd.exp_b, opnd.mant_b};

   assign exp_big    = a_big ? opnd.exp_a : opnd.exp_b;
   assign exp_diff   = a_big ? opnd.exp_a - opnd.exp_b : opnd.exp_b - opnd.exp_a;
   assign mant_big   = a_big ? opnd.mant_a : opnd.mant_b;
   assign mant_small = a_big ? opnd.mant_b : opnd.mant_a;

   //////////////////////////////////////////////////////////////////////
   // Alignment
   //////////////////////////////////////////////////////////////////////
   // Hidden bit at 46, bit 47 left free for the carry
   assign big_al   = {1'b0, mant_big, {`FPU_MANT_W{1'b0}}};
   assign small_al = {1'b0, mant_small, {`FPU_MANT_W{1'b0}}};

   // 23 spare low bits hold guard and round
   assign small_sh = small_al >> exp_diff;
   // Anything shifted out
   assign sticky = (small_sh << exp_diff) != small_al;

   //////////////////////////////////////////////////////////////////////
   // Magnitude add or subtract
   //////////////////////////////////////////////////////////////////////
   // Opposite signs subtract
   assign sub = opnd.sign_a ^ opnd.sign_b;

   // Larger operand decides the sign
   assign sign = a_big ? opnd.sign_a : opnd.sign_b;
   assign exp  = $signed({2'b00, exp_big});

   // Sticky jammed into the lsb, far below the round position
   assign mant = sub ? big_al - (small_sh | sticky) : big_al + (small_sh | sticky);

endmodule

//--- hw/fpu_mult_path.sv
// Multiply path with product sign, biased exponent sum and full mantissa product
`include "fpu_defines.svh"

module fpu_mult_path
(
   fpu_operand_if.sink                         opnd,
   output logic                                sign,
   output logic signed [`FPU_PRENORM_EXP_W-1:0] exp,
   output logic [`FPU_PRENORM_MANT_W-1:0]       mant
);

   logic signed [`FPU_PRENORM_EXP_W-1:0] exp_a;
   logic signed [`FPU_PRENORM_EXP_W-1:0] exp_b;

   // Sign of a product
   assign sign = opnd.sign_a ^ opnd.sign_b;

   // Exponents widened so the sum keeps its range
   assign exp_a = $signed({2'b00, opnd.exp_a});
   assign exp_b = $signed({2'b00, opnd.exp_b});

   // One bias removed, result stays biased
   assign exp = exp_a + exp_b - `FPU_BIAS;

   // 1.23 times 1.23, leading one lands at bit 47 or 46
   assign mant = opnd.mant_a * opnd.mant_b;

endmodule

//--- hw/fpu_round_special.sv
// Path select, normalization, round to nearest even and special case resolution
`include "fpu_defines.svh"

module fpu_round_special
(
   fpu_operand_if.sink                        opnd,
   input logic                                add_sign,
   input logic signed [`FPU_PRENORM_EXP_W-1:0] add_exp,
   input logic [`FPU_PRENORM_MANT_W-1:0]       add_mant,
   input logic                                mult_sign,
   input logic signed [`FPU_PRENORM_EXP_W-1:0] mult_exp,
   input logic [`FPU_PRENORM_MANT_W-1:0]       mult_mant,
   fpu_result_if.source                       res
);

   logic                                is_mul;
   logic                                sel_sign;
   logic signed [`FPU_PRENORM_EXP_W-1:0] sel_exp;
   logic [`FPU_PRENORM_MANT_W-1:0]       sel_mant;
   logic [5:0]                          lead;
   logic [`FPU_PRENORM_MANT_W-1:0]       norm_mant;
   logic signed [`FPU_PRENORM_EXP_W-1:0] norm_exp;
   logic                                guard;
   logic                                sticky;
   logic [`FPU_MANT_W+1:0]              rnd_mant;
   logic                                a_inf;
   logic                                b_inf;
   logic                                a_zero;
   logic                                b_zero;
   logic                                invalid;

   //////////////////////////////////////////////////////////////////////
   // Path select and normalization
   //////////////////////////////////////////////////////////////////////
   assign is_mul   = (opnd.op == fpu_pkg::OP_MUL);
   assign sel_sign = is_mul ? mult_sign : add_sign;
   assign sel_exp  = is_mul ? mult_exp : add_exp;
   assign sel_mant = is_mul ? mult_mant : add_mant;

   // Leading one, highest set bit wins
   always_comb
   begin
      lead = '0;
      for (int i = 0; i < `FPU_PRENORM_MANT_W; i++)
      begin
         if (sel_mant[i])
            lead = 6'(i);
      end
   end

   // Leading one to bit 47
   assign norm_mant = sel_mant << (6'(`FPU_PRENORM_MANT_W - 1) - lead);
   // Bit 46 is the reference position
   assign norm_exp  = sel_exp + $signed({4'b0000, lead}) - (`FPU_PRENORM_MANT_W - 2);

   //////////////////////////////////////////////////////////////////////
   // Round to nearest even
   //////////////////////////////////////////////////////////////////////
   assign guard  = norm_mant[`FPU_PRENORM_MANT_W-`FPU_MANT_W-2];
   assign sticky = |norm_mant[`FPU_PRENORM_MANT_W-`FPU_MANT_W-3:0];

   // Up on more than half, ties go to an even lsb
   assign rnd_mant = {1'b0, norm_mant[`FPU_PRENORM_MANT_W-1:`FPU_PRENORM_MANT_W-`FPU_MANT_W-1]}
                     + (guard & (sticky | norm_mant[`FPU_PRENORM_MANT_W-`FPU_MANT_W-1]));

   // Carry out renormalizes by one
   assign res.mant    = rnd_mant[`FPU_MANT_W+1] ? rnd_mant[`FPU_MANT_W+1:1]
                                                : rnd_mant[`FPU_MANT_W:0];
   assign res.exp     = norm_exp + {{(`FPU_PRENORM_EXP_W-1){1'b0}}, rnd_mant[`FPU_MANT_W+1]};
   assign res.inexact = guard | sticky;
   assign res.valid   = opnd.valid;

   //////////////////////////////////////////////////////////////////////
   // Special cases
   //////////////////////////////////////////////////////////////////////
   assign a_inf  = (opnd.class_a == fpu_pkg::CLASS_INF);
   assign b_inf  = (opnd.class_b == fpu_pkg::CLASS_INF);
   assign a_zero = (opnd.class_a == fpu_pkg::CLASS_ZERO);
   assign b_zero = (opnd.class_b == fpu_pkg::CLASS_ZERO);

   // NaN in, inf minus inf, zero times inf
   assign invalid = (opnd.class_a == fpu_pkg::CLASS_NAN) || (opnd.class_b == fpu_pkg::CLASS_NAN)
                    || (is_mul && ((a_inf && b_zero) || (a_zero && b_inf)))
                    || (!is_mul && a_inf && b_inf && (opnd.sign_a != opnd.sign_b));

   always_comb
   begin
      res.special = fpu_pkg::SPECIAL_NONE;
      res.sign    = sel_sign;
      if (invalid)
         res.special = fpu_pkg::SPECIAL_QNAN;
      else if (a_inf || b_inf)
      begin
         res.special = fpu_pkg::SPECIAL_INF;
         // Sum takes the sign of the infinite operand
         if (!is_mul)
            res.sign = a_inf ? opnd.sign_a : opnd.sign_b;
      end
      else if (sel_mant == '0)
      begin
         res.special = fpu_pkg::SPECIAL_ZERO;
         // Exact zero sum is positive, a product keeps the xor
         if (!is_mul)
            res.sign = 1'b0;
      end
   end

endmodule

//--- hw/fpu_result_stage.sv
// Output stage with range check, word packing, flag derivation and result register
`include "fpu_defines.svh"

module fpu_result_stage
(
   input  logic                   Clk_CI,
   input  logic                   Rst_RBI,
   fpu_result_if.sink             res,
   output logic [`FPU_WORD_W-1:0] result,
   output logic                   valid,
   output logic                   of,
   output logic                   uf,
   output logic                   zero,
   output logic                   ix,
   output logic                   iv,
   output logic                   inf
);

   logic [`FPU_WORD_W-1:0] word_d;
   fpu_pkg::fpu_flags_t    flags_d;
   fpu_pkg::fpu_flags_t    flags_q;

   //////////////////////////////////////////////////////////////////////
   // Packing and flags
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      word_d  = {res.sign, res.exp[`FPU_EXP_W-1:0], res.mant[`FPU_MANT_W-1:0]};
      flags_d = '0;
      case (res.special)
         fpu_pkg::SPECIAL_QNAN:
         begin
            word_d     = `FPU_QNAN;
            flags_d.iv = 1'b1;
         end
         fpu_pkg::SPECIAL_INF:
         begin
            word_d      = {res.sign, `FPU_EXP_INF, {`FPU_MANT_W{1'b0}}};
            flags_d.inf = 1'b1;
         end
         fpu_pkg::SPECIAL_ZERO:
         begin
            word_d       = {res.sign, {(`FPU_WORD_W-1){1'b0}}};
            flags_d.zero = 1'b1;
         end
         default:
         begin
            flags_d.ix = res.inexact;
            // Past the largest normal
            if (res.exp >= $signed({2'b00, `FPU_EXP_INF}))
            begin
               word_d      = {res.sign, `FPU_EXP_INF, {`FPU_MANT_W{1'b0}}};
               flags_d.of  = 1'b1;
               flags_d.ix  = 1'b1;
               flags_d.inf = 1'b1;
            end
            // Below the smallest normal, flush to signed zero
            else if (res.exp <= 0)
            begin
               word_d       = {res.sign, {(`FPU_WORD_W-1){1'b0}}};
               flags_d.uf   = 1'b1;
               flags_d.ix   = 1'b1;
               flags_d.zero = 1'b1;
            end
         end
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Output register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         result  <= '0;
         flags_q <= '0;
         valid   <= 1'b0;
      end
      else
      begin
         result  <= word_d;
         flags_q <= flags_d;
         valid   <= res.valid;
      end
   end

   assign of   = flags_q.of;
   assign uf   = flags_q.uf;
   assign zero = flags_q.zero;
   assign ix   = flags_q.ix;
   assign iv   = flags_q.iv;
   assign inf  = flags_q.inf;

endmodule

//--- hw/fpu_top.sv
// FPU top level connecting the operand stage, both paths, rounding and result stage
`include "fpu_defines.svh"

module fpu_top
(
   input  logic                   Clk_CI,
   input  logic                   Rst_RBI,
   input  logic                   enable,
   input  logic [`FPU_WORD_W-1:0] operand_a,
   input  logic [`FPU_WORD_W-1:0] operand_b,
   input  fpu_pkg::fpu_op_e       op,
   output logic [`FPU_WORD_W-1:0] result,
   output logic                   valid,
   output logic                   of,
   output logic                   uf,
   output logic                   zero,
   output logic                   ix,
   output logic                   iv,
   output logic                   inf
);

   // Stage links
   fpu_operand_if opnd ();
   fpu_result_if  res ();

   // Prenormalized path outputs
   logic                                add_sign;
   logic signed [`FPU_PRENORM_EXP_W-1:0] add_exp;
   logic [`FPU_PRENORM_MANT_W-1:0]       add_mant;
   logic                                mult_sign;
   logic signed [`FPU_PRENORM_EXP_W-1:0] mult_exp;
   logic [`FPU_PRENORM_MANT_W-1:0]       mult_mant;

   fpu_operand_stage operand_stage0
   (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .enable    (enable),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .op        (op),
      .opnd      (opnd.source)
   );

   fpu_add_path add_path0
   (
      .opnd (opnd.sink),
      .sign (add_sign),
      .exp  (add_exp),
      .mant (add_mant)
   );

   fpu_mult_path mult_path0
   (
      .opnd (opnd.sink),
      .sign (mult_sign),
      .exp  (mult_exp),
      .mant (mult_mant)
   );

   fpu_round_special round_special0
   (
      .opnd      (opnd.sink),
      .add_sign  (add_sign),
      .add_exp   (add_exp),
      .add_mant  (add_mant),
      .mult_sign (mult_sign),
      .mult_exp  (mult_exp),
      .mult_mant (mult_mant),
      .res       (res.source)
   );

   fpu_result_stage result_stage0
   (
      .Clk_CI  (Clk_CI),
      .Rst_RBI (Rst_RBI),
      .res     (res.sink),
      .result  (result),
      .valid   (valid),
      .of      (of),
      .uf      (uf),
      .zero    (zero),
      .ix      (ix),
      .iv      (iv),
      .inf     (inf)
   );

endmodule

//--- dv/fpu_tb.sv
// Testbench for fpu_top with clock, reset, directed tests, pipelining test and timeout
`include "fpu_defines.svh"

module fpu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // Covers reset, 19 directed vectors of 3 cycles and 40 pipelined requests of up to 3 cycles
   localparam int max_cycles = 400;

   // Flag order of, uf, zero, ix, iv, inf
   localparam logic [5:0] f_none = 6'b000000;
   localparam logic [5:0] f_of   = 6'b100000;
   localparam logic [5:0] f_uf   = 6'b010000;
   localparam logic [5:0] f_zero = 6'b001000;
   localparam logic [5:0] f_ix   = 6'b000100;
   localparam logic [5:0] f_iv   = 6'b000010;
   localparam logic [5:0] f_inf  = 6'b000001;

   logic                   Clk_CI;
   logic                   Rst_RBI;
   logic                   enable;
   logic [`FPU_WORD_W-1:0] operand_a;
   logic [`FPU_WORD_W-1:0] operand_b;
   fpu_pkg::fpu_op_e       op;
   logic [`FPU_WORD_W-1:0] result;
   logic                   valid;
   logic                   of;
   logic                   uf;
   logic                   zero;
   logic                   ix;
   logic                   iv;
   logic                   inf;

   // Expected outputs per slot
   // Slot 1 falls due at the current falling edge
   logic                   exp_valid [2];
   logic [`FPU_WORD_W-1:0] exp_word  [2];
   logic [5:0]             exp_flags [2];

   // Directed test vectors replayed later in random order
   logic [`FPU_WORD_W-1:0] vec_a     [$];
   logic [`FPU_WORD_W-1:0] vec_b     [$];
   fpu_pkg::fpu_op_e       vec_op    [$];
   logic [`FPU_WORD_W-1:0] vec_word  [$];
   logic [5:0]             vec_flags [$];

   integer seed;
   int     cycle_count = 0;

   fpu_top dut0
   (
      .Clk_CI    (Clk_CI),
      .Rst_RBI   (Rst_RBI),
      .enable    (enable),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .op        (op),
      .result    (result),
      .valid     (valid),
      .of        (of),
      .uf        (uf),
      .zero      (zero),
      .ix        (ix),
      .iv        (iv),
      .inf       (inf)
   );

   // 8 ns period
   always #4 Clk_CI = ~Clk_CI;

   always @(posedge Clk_CI)
   begin
      cycle_count++;
      if (cycle_count >= max_cycles)
      begin
         $display("Timeout, the tests did not finish within %0d cycles", max_cycles);
         abort_run();
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Failure handling and output checks
   //////////////////////////////////////////////////////////////////////
   task automatic abort_run();
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic mismatch(input string msg);
      $display("Mismatch at %0d ns: %s", $time, msg);
      abort_run();
   endtask

   // Compare outputs against the request issued two cycles ago
   task automatic check_outputs();
      logic [5:0] flags;
      flags = {of, uf, zero, ix, iv, inf};
      assert (valid === exp_valid[1])
      else
         mismatch($sformatf("valid is %b, expected %b", valid, exp_valid[1]));
      if (exp_valid[1])
      begin
         assert (result === exp_word[1])
         else
            mismatch($sformatf("result %h, expected %h", result, exp_word[1]));
         assert (flags === exp_flags[1])
         else
            mismatch($sformatf("flags of,uf,zero,ix,iv,inf %b, expected %b",
                               flags, exp_flags[1]));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////
   // One cycle that checks at the falling edge and then drives the next request
   task automatic step(input logic req, input logic [`FPU_WORD_W-1:0] a,
                       input logic [`FPU_WORD_W-1:0] b, input fpu_pkg::fpu_op_e o,
                       input logic [`FPU_WORD_W-1:0] word, input logic [5:0] flags);
      @(negedge Clk_CI);
      check_outputs();
      exp_valid[1] = exp_valid[0];
      exp_word[1]  = exp_word[0];
      exp_flags[1] = exp_flags[0];
      exp_valid[0] = req;
      exp_word[0]  = word;
      exp_flags[0] = flags;
      enable       = req;
      operand_a    = a;
      operand_b    = b;
      op           = o;
   endtask

   task automatic idle_cycle();
      step(1'b0, '0, '0, fpu_pkg::OP_ADD, '0, f_none);
   endtask

   // Single request followed by a drain so its result gets checked
   task automatic run_vector(input logic [`FPU_WORD_W-1:0] a, input logic [`FPU_WORD_W-1:0] b,
                             input fpu_pkg::fpu_op_e o, input logic [`FPU_WORD_W-1:0] word,
                             input logic [5:0] flags);
      vec_a.push_back(a);
      vec_b.push_back(b);
      vec_op.push_back(o);
      vec_word.push_back(word);
      vec_flags.push_back(flags);
      step(1'b1, a, b, o, word, flags);
      idle_cycle();
      idle_cycle();
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////
   task automatic test_reset();
      Rst_RBI = 1'b0;
      repeat (16) @(posedge Clk_CI);
      @(negedge Clk_CI);
      assert (result === '0 && valid === 1'b0 && {of, uf, zero, ix, iv, inf} === f_none)
      else
         mismatch("outputs not cleared during reset");
      Rst_RBI = 1'b1;
   endtask

   task automatic test_exact_add_sub();
      // 1 + 2 = 3, 3 - 1 = 2
      run_vector(32'h3f800000, 32'h40000000, fpu_pkg::OP_ADD, 32'h40400000, f_none);
      run_vector(32'h40400000, 32'h3f800000, fpu_pkg::OP_SUB, 32'h40000000, f_none);
      // Exact zero sums are +0
      run_vector(32'h40400000, 32'h40400000, fpu_pkg::OP_SUB, 32'h00000000, f_zero);
      run_vector(32'hc0400000, 32'h40400000, fpu_pkg::OP_ADD, 32'h00000000, f_zero);
   endtask

   task automatic test_multiply();
      // 1.5 * -2 = -3
      run_vector(32'h3fc00000, 32'hc0000000, fpu_pkg::OP_MUL, 32'hc0400000, f_none);
      // 3 * 3 = 9 with a one-bit product normalization
      run_vector(32'h40400000, 32'h40400000, fpu_pkg::OP_MUL, 32'h41100000, f_none);
      // -0 * 5 keeps the xor sign
      run_vector(32'h80000000, 32'h40a00000, fpu_pkg::OP_MUL, 32'h80000000, f_zero);
   endtask

   task automatic test_rounding();
      // Tie on 1 + 2^-24 stays on the even lsb
      run_vector(32'h3f800000, 32'h33800000, fpu_pkg::OP_ADD, 32'h3f800000, f_ix);
      // Tie with an odd lsb rounds up
      run_vector(32'h3f800001, 32'h33800000, fpu_pkg::OP_ADD, 32'h3f800002, f_ix);
      // Above half rounds up
      run_vector(32'h3f800000, 32'h33c00000, fpu_pkg::OP_ADD, 32'h3f800001, f_ix);
   endtask

   task automatic test_range();
      run_vector(32'h7f7fffff, 32'h40000000, fpu_pkg::OP_MUL, 32'h7f800000,
                 f_of | f_ix | f_inf);
      run_vector(32'hff7fffff, 32'h40000000, fpu_pkg::OP_MUL, 32'hff800000,
                 f_of | f_ix | f_inf);
      // 2^-100 squared flushes to zero
      run_vector(32'h0d800000, 32'h0d800000, fpu_pkg::OP_MUL, 32'h00000000,
                 f_uf | f_ix | f_zero);
   endtask

   task automatic test_special();
      // Invalid cases give the quiet NaN
      run_vector(32'h7f800000, 32'h7f800000, fpu_pkg::OP_SUB, 32'h7fc00000, f_iv);
      run_vector(32'h00000000, 32'h7f800000, fpu_pkg::OP_MUL, 32'h7fc00000, f_iv);
      run_vector(32'h7fc00001, 32'h3f800000, fpu_pkg::OP_ADD, 32'h7fc00000, f_iv);
      run_vector(32'h3f800000, 32'hffc00000, fpu_pkg::OP_MUL, 32'h7fc00000, f_iv);
      // Infinite operands pass through
      run_vector(32'h7f800000, 32'h3f800000, fpu_pkg::OP_ADD, 32'h7f800000, f_inf);
      run_vector(32'hff800000, 32'h3f800000, fpu_pkg::OP_MUL, 32'hff800000, f_inf);
   endtask

   // Random order and gaps over the collected vectors
   task automatic test_pipeline();
      int n;
      int idx;
      int gap;
      for (n = 0; n < 40; n++)
      begin
         idx = {$random(seed)} % vec_a.size();
         gap = {$random(seed)} % 3;
         step(1'b1, vec_a[idx], vec_b[idx], vec_op[idx], vec_word[idx], vec_flags[idx]);
         repeat (gap) idle_cycle();
      end
      // Drain the last two requests
      idle_cycle();
      idle_cycle();
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      seed         = 32'h3c41;
      Clk_CI       = 1'b0;
      Rst_RBI      = 1'b0;
      enable       = 1'b0;
      operand_a    = '0;
      operand_b    = '0;
      op           = fpu_pkg::OP_ADD;
      exp_valid[0] = 1'b0;
      exp_valid[1] = 1'b0;
      exp_word[0]  = '0;
      exp_word[1]  = '0;
      exp_flags[0] = f_none;
      exp_flags[1] = f_none;

      test_reset();
      test_exact_add_sub();
      test_multiply();
      test_rounding();
      test_range();
      test_special();
      test_pipeline();

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- all.f
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_if.sv
hw/fpu_operand_stage.sv
hw/fpu_add_path.sv
hw/fpu_mult_path.sv
hw/fpu_round_special.sv
hw/fpu_result_stage.sv
hw/fpu_top.sv
dv/fpu_tb.sv

//--- Makefile
# Verilator build and run of the FPU testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
